// File: design/cpu_pkg.sv
package cpu_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and fixed addresses
    //////////////////////////////////////////////////////////////////////

    localparam int XLEN     = 64;
    localparam int REG_ID_W = 5;

    // r31 holds the program counter
    localparam logic [REG_ID_W-1:0] REG_PC = 5'd31;

    localparam logic [XLEN-1:0] RESET_PC    = 64'h0000_8000_0000_0000;
    localparam logic [XLEN-1:0] INSTR_BYTES = 64'd8;

    //////////////////////////////////////////////////////////////////////
    // instruction encoding
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [6:0] {
        OP_NOP     = 7'h00,
        OP_SET     = 7'h01,
        OP_LOAD    = 7'h02,
        OP_STORE   = 7'h03,
        OP_JUMP    = 7'h04,
        OP_TESTBIT = 7'h05,
        OP_SUB     = 7'h06,
        OP_SHIFTL  = 7'h07,
        OP_OR      = 7'h08,
        OP_AND     = 7'h09,
        OP_XOR     = 7'h0a,
        OP_ADD     = 7'h0b,
        OP_SHIFTR  = 7'h0c,
        OP_CALL    = 7'h0d,
        OP_HALT    = 7'h7f
    } opcode_e;

    typedef enum logic [1:0] {
        FMT_RRO = 2'd0,
        FMT_RIS = 2'd1,
        FMT_I   = 2'd2
    } format_e;

    // condition field values, anything else runs unconditionally
    localparam logic [3:0] COND_Z  = 4'b0001;
    localparam logic [3:0] COND_NZ = 4'b1001;

    // common to all three formats, bits 63..51
    typedef struct packed {
        opcode_e    opcode;
        format_e    fmt;
        logic [3:0] cond;
    } instr_hdr_t;

    typedef struct packed {
        instr_hdr_t  hdr;
        logic [4:0]  dst;
        logic [4:0]  src;
        logic [40:0] off;
    } instr_rro_t;

    typedef struct packed {
        instr_hdr_t  hdr;
        logic [4:0]  reg_id;
        logic [40:0] imm;
        logic [4:0]  shl;
    } instr_ris_t;

    typedef struct packed {
        instr_hdr_t  hdr;
        logic [50:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_rro_t rro;
        instr_ris_t ris;
        instr_i_t   i;
    } instr_t;

    //////////////////////////////////////////////////////////////////////
    // bus and unit results
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic            we;
        logic [XLEN-1:0] adr;
        logic [XLEN-1:0] dat;
    } bus_req_t;

    typedef struct packed {
        logic            ack;
        logic            err;
        logic [XLEN-1:0] dat;
    } bus_rsp_t;

    typedef struct packed {
        logic            we;
        logic            flag;
        logic [XLEN-1:0] val;
    } exec_res_t;

endpackage

// File: design/cpu_regfile.sv
module cpu_regfile (
    input  logic                         clk_i,
    input  logic                         we_i,
    input  logic [cpu_pkg::REG_ID_W-1:0] reg_id_i,
    input  logic [cpu_pkg::XLEN-1:0]     reg_dat_i,
    output logic [cpu_pkg::XLEN-1:0]     reg_dat_o
);
    import cpu_pkg::*;

    logic [XLEN-1:0] regs_q [0:REG_PC];

    // single port, a write blocks the read in the same cycle
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            regs_q[reg_id_i] <= reg_dat_i;
        end else begin
            reg_dat_o <= regs_q[reg_id_i];
        end
    end

endmodule

// File: design/cpu_alu.sv
module cpu_alu (
    input  cpu_pkg::instr_t          instr_i,
    input  logic [cpu_pkg::XLEN-1:0] dst_val_i,
    input  logic [cpu_pkg::XLEN-1:0] src_val_i,
    output cpu_pkg::exec_res_t       res_o
);
    import cpu_pkg::*;

    logic [XLEN-1:0] imm_zx;
    logic            shamt_big;
    logic [5:0]      shamt;

    assign imm_zx    = XLEN'(instr_i.ris.imm);
    // shift distances past the word width give zero
    assign shamt_big = (imm_zx >= XLEN);
    assign shamt     = imm_zx[5:0];

    always_comb begin
        res_o.we  = 1'b1;
        res_o.val = '0;
        case (instr_i.ris.hdr.opcode)
            OP_SET: begin
                if (instr_i.ris.hdr.fmt == FMT_RRO) begin
                    res_o.val = src_val_i;
                end else begin
                    res_o.val = imm_zx << instr_i.ris.shl;
                end
            end
            OP_ADD: res_o.val = dst_val_i + imm_zx;
            OP_SUB: res_o.val = dst_val_i - imm_zx;
            OP_SHIFTL: begin
                if (!shamt_big) begin
                    res_o.val = dst_val_i << shamt;
                end
            end
            OP_SHIFTR: begin
                if (!shamt_big) begin
                    res_o.val = dst_val_i >> shamt;
                end
            end
            OP_OR:  res_o.val = dst_val_i | src_val_i;
            OP_AND: res_o.val = dst_val_i & src_val_i;
            OP_XOR: res_o.val = dst_val_i ^ src_val_i;
            default: res_o.we = 1'b0;
        endcase
        // zero indication, the sequencer only takes it for sub
        res_o.flag = (res_o.val == '0);
    end

endmodule

// File: design/cpu_branch.sv
module cpu_branch (
    input  cpu_pkg::instr_t          instr_i,
    input  logic [cpu_pkg::XLEN-1:0] dst_val_i,
    output cpu_pkg::exec_res_t       res_o
);
    import cpu_pkg::*;

    logic [XLEN-1:0] bit_idx;
    logic            bit_set;

    assign bit_idx = XLEN'(instr_i.ris.imm);
    // out of range index reads as a clear bit
    assign bit_set = (bit_idx < XLEN) ? dst_val_i[bit_idx[$clog2(XLEN)-1:0]] : 1'b0;

    always_comb begin
        res_o.we   = 1'b0;
        res_o.flag = 1'b0;
        res_o.val  = '0;
        case (instr_i.i.hdr.opcode)
            OP_JUMP: begin
                res_o.we = 1'b1;
                if (instr_i.i.hdr.fmt == FMT_RIS) begin
                    res_o.val = dst_val_i;
                end else begin
                    res_o.val = XLEN'(instr_i.i.imm);
                end
            end
            OP_CALL: begin
                // offset is signed, so calls can go backwards
                res_o.we  = 1'b1;
                res_o.val = dst_val_i + XLEN'($signed(instr_i.rro.off));
            end
            OP_TESTBIT: res_o.flag = !bit_set;
            default: res_o.we = 1'b0;
        endcase
    end

endmodule

// File: design/cpu_sequencer.sv
module cpu_sequencer (
    input  logic                         clk_i,
    input  logic                         rst_i,
    output cpu_pkg::bus_req_t            bus_req_o,
    input  cpu_pkg::bus_rsp_t            bus_rsp_i,
    output logic                         halted_o,
    output logic                         rf_we_o,
    output logic [cpu_pkg::REG_ID_W-1:0] rf_id_o,
    output logic [cpu_pkg::XLEN-1:0]     rf_dat_o,
    input  logic [cpu_pkg::XLEN-1:0]     rf_dat_i,
    output cpu_pkg::instr_t              instr_o,
    output logic [cpu_pkg::XLEN-1:0]     dst_val_o,
    output logic [cpu_pkg::XLEN-1:0]     src_val_o,
    input  cpu_pkg::exec_res_t           alu_res_i,
    input  cpu_pkg::exec_res_t           br_res_i
);
    import cpu_pkg::*;

    typedef enum logic [3:0] {
        S_WB,
        S_PC_RD,
        S_FETCH,
        S_DECODE,
        S_DST_RD,
        S_DST_LATCH,
        S_SRC_RD,
        S_SRC_LATCH,
        S_EXEC,
        S_MEM,
        S_HALT
    } state_e;

    state_e              state_q;
    bus_req_t            req_q;
    instr_t              instr_q;
    instr_t              fetched;
    logic                z_q;
    logic                skip;
    logic [XLEN-1:0]     dst_val_q;
    logic [XLEN-1:0]     src_val_q;
    logic                rf_we_q;
    logic [REG_ID_W-1:0] rf_id_q;
    logic [XLEN-1:0]     rf_dat_q;
    logic [REG_ID_W-1:0] dst_id;
    logic [XLEN-1:0]     off_zx;

    //////////////////////////////////////////////////////////////////////
    // decode helpers
    //////////////////////////////////////////////////////////////////////

    assign fetched = bus_rsp_i.dat;

    // .z and .nz against the current flag
    assign skip = ((fetched.i.hdr.cond == COND_Z) && !z_q) ||
                  ((fetched.i.hdr.cond == COND_NZ) && z_q);

    assign dst_id = instr_q.rro.dst;
    assign off_zx = XLEN'(instr_q.rro.off);

    //////////////////////////////////////////////////////////////////////
    // main state machine
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= S_WB;
            req_q.cyc <= 1'b0;
            req_q.stb <= 1'b0;
            req_q.we  <= 1'b0;
            z_q       <= 1'b0;
            // pc gets loaded every reset cycle
            rf_we_q   <= 1'b1;
            rf_id_q   <= REG_PC;
            rf_dat_q  <= RESET_PC;
        end else begin
            case (state_q)
                S_WB: begin
                    // pending write lands here, then point the port at the pc
                    rf_we_q <= 1'b0;
                    rf_id_q <= REG_PC;
                    state_q <= S_PC_RD;
                end
                S_PC_RD: state_q <= S_FETCH;
                S_FETCH: begin
                    req_q.cyc <= 1'b1;
                    req_q.stb <= 1'b1;
                    req_q.we  <= 1'b0;
                    req_q.adr <= rf_dat_i;
                    // bump the pc while the fetch is out
                    rf_we_q   <= 1'b1;
                    rf_dat_q  <= rf_dat_i + INSTR_BYTES;
                    state_q   <= S_DECODE;
                end
                S_DECODE: begin
                    rf_we_q <= 1'b0;
                    if (bus_rsp_i.ack) begin
                        req_q.cyc <= 1'b0;
                        req_q.stb <= 1'b0;
                        instr_q   <= fetched;
                        // rro dst and ris reg sit in the same bits
                        rf_id_q   <= fetched.rro.dst;
                        if (skip) begin
                            state_q <= S_WB;
                        end else if (fetched.i.hdr.fmt == FMT_I) begin
                            state_q <= S_EXEC;
                        end else begin
                            state_q <= S_DST_RD;
                        end
                    end else if (bus_rsp_i.err) begin
                        req_q.cyc <= 1'b0;
                        req_q.stb <= 1'b0;
                        state_q   <= S_HALT;
                    end
                end
                S_DST_RD: state_q <= S_DST_LATCH;
                S_DST_LATCH: begin
                    dst_val_q <= rf_dat_i;
                    if (instr_q.i.hdr.fmt == FMT_RRO) begin
                        rf_id_q <= instr_q.rro.src;
                        state_q <= S_SRC_RD;
                    end else begin
                        state_q <= S_EXEC;
                    end
                end
                S_SRC_RD: state_q <= S_SRC_LATCH;
                S_SRC_LATCH: begin
                    src_val_q <= rf_dat_i;
                    state_q   <= S_EXEC;
                end
                S_EXEC: begin
                    case (instr_q.i.hdr.opcode)
                        OP_LOAD: begin
                            req_q.cyc <= 1'b1;
                            req_q.stb <= 1'b1;
                            req_q.we  <= 1'b0;
                            req_q.adr <= src_val_q + off_zx;
                            state_q   <= S_MEM;
                        end
                        OP_STORE: begin
                            req_q.cyc <= 1'b1;
                            req_q.stb <= 1'b1;
                            req_q.we  <= 1'b1;
                            req_q.adr <= dst_val_q + off_zx;
                            req_q.dat <= src_val_q;
                            state_q   <= S_MEM;
                        end
                        OP_HALT: state_q <= S_HALT;
                        default: begin
                            // branch unit owns the pc, alu owns the rest
                            if (br_res_i.we) begin
                                rf_we_q  <= 1'b1;
                                rf_id_q  <= REG_PC;
                                rf_dat_q <= br_res_i.val;
                            end else if (alu_res_i.we) begin
                                rf_we_q  <= 1'b1;
                                rf_id_q  <= dst_id;
                                rf_dat_q <= alu_res_i.val;
                            end
                            if (instr_q.i.hdr.opcode == OP_SUB) begin
                                z_q <= alu_res_i.flag;
                            end else if (instr_q.i.hdr.opcode == OP_TESTBIT) begin
                                z_q <= br_res_i.flag;
                            end
                            state_q <= S_WB;
                        end
                    endcase
                end
                S_MEM: begin
                    if (bus_rsp_i.ack || bus_rsp_i.err) begin
                        req_q.cyc <= 1'b0;
                        req_q.stb <= 1'b0;
                        req_q.we  <= 1'b0;
                        // load data only on a good read
                        if (bus_rsp_i.ack && !req_q.we) begin
                            rf_we_q  <= 1'b1;
                            rf_id_q  <= instr_q.rro.dst;
                            rf_dat_q <= bus_rsp_i.dat;
                        end
                        state_q <= S_WB;
                    end
                end
                // parked until reset
                default: state_q <= S_HALT;
            endcase
        end
    end

    assign bus_req_o = req_q;
    assign halted_o  = (state_q == S_HALT);
    assign rf_we_o   = rf_we_q;
    assign rf_id_o   = rf_id_q;
    assign rf_dat_o  = rf_dat_q;
    assign instr_o   = instr_q;
    assign dst_val_o = dst_val_q;
    assign src_val_o = src_val_q;

endmodule

// File: design/cpu_top.sv
module cpu_top (
    input  logic              clk_i,
    input  logic              rst_i,
    output cpu_pkg::bus_req_t bus_req_o,
    input  cpu_pkg::bus_rsp_t bus_rsp_i,
    output logic              halted_o
);
    import cpu_pkg::*;

    logic                rf_we;
    logic [REG_ID_W-1:0] rf_id;
    logic [XLEN-1:0]     rf_wdat;
    logic [XLEN-1:0]     rf_rdat;
    instr_t              instr;
    logic [XLEN-1:0]     dst_val;
    logic [XLEN-1:0]     src_val;
    exec_res_t           alu_res;
    exec_res_t           br_res;

    cpu_sequencer u_sequencer (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .bus_req_o (bus_req_o),
        .bus_rsp_i (bus_rsp_i),
        .halted_o  (halted_o),
        .rf_we_o   (rf_we),
        .rf_id_o   (rf_id),
        .rf_dat_o  (rf_wdat),
        .rf_dat_i  (rf_rdat),
        .instr_o   (instr),
        .dst_val_o (dst_val),
        .src_val_o (src_val),
        .alu_res_i (alu_res),
        .br_res_i  (br_res)
    );

    cpu_regfile u_regfile (
        .clk_i     (clk_i),
        .we_i      (rf_we),
        .reg_id_i  (rf_id),
        .reg_dat_i (rf_wdat),
        .reg_dat_o (rf_rdat)
    );

    // both units see the same operands, the sequencer picks
    cpu_alu u_alu (
        .instr_i   (instr),
        .dst_val_i (dst_val),
        .src_val_i (src_val),
        .res_o     (alu_res)
    );

    cpu_branch u_branch (
        .instr_i   (instr),
        .dst_val_i (dst_val),
        .res_o     (br_res)
    );

endmodule

// File: test/cpu_properties.sv
module cpu_properties (
    input logic              clk_i,
    input logic              rst_i,
    input cpu_pkg::bus_req_t bus_req_o,
    input cpu_pkg::bus_rsp_t bus_rsp_i,
    input logic              halted_o
);
    import cpu_pkg::*;

    // strobe only inside a cycle
    a_stb_in_cyc: assert property (
        @(posedge clk_i) disable iff (rst_i)
        bus_req_o.stb |-> bus_req_o.cyc
    ) else $error("bus stb high while cyc is low");

    // request holds until the slave answers
    a_req_stable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (bus_req_o.stb && !bus_rsp_i.ack && !bus_rsp_i.err) |=> $stable(bus_req_o)
    ) else $error("bus request changed before ack or err");

    a_quiet_when_halted: assert property (
        @(posedge clk_i) disable iff (rst_i)
        halted_o |-> !bus_req_o.stb
    ) else $error("bus request while core is halted");

    a_idle_in_reset: assert property (
        @(posedge clk_i)
        rst_i |=> (!bus_req_o.cyc && !bus_req_o.stb)
    ) else $error("bus active during reset");

endmodule

// File: test/cpu_tb.sv
module cpu_tb;
    import cpu_pkg::*;

    localparam int          CLK_PERIOD = 4;
    localparam logic [3:0]  AL         = 4'h0;
    localparam logic [63:0] LAND       = RESET_PC + 64'h100;
    localparam logic [63:0] DATA_ADR   = 64'h2000;
    localparam logic [63:0] DATA_WORD  = 64'h0123_4567_89ab_cdef;

    // one test program with the single store it should make
    typedef struct packed {
        logic [5:0][63:0] words;
        logic             has_st;
        logic [63:0]      st_adr;
        logic [63:0]      st_dat;
        logic             err;
    } row_t;

    logic     clk_i;
    logic     rst_i;
    bus_req_t bus_req;
    bus_rsp_t bus_rsp;
    logic     halted;

    row_t        rows[$];
    logic [63:0] mem [logic [63:0]];
    logic [63:0] read_q[$];
    logic [63:0] st_adr_q[$];
    logic [63:0] st_dat_q[$];
    logic        err_seen;
    logic        table_ready;
    logic [31:0] lfsr_q;
    int          errors;

    cpu_top cpu_top_inst (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .bus_req_o (bus_req),
        .bus_rsp_i (bus_rsp),
        .halted_o  (halted)
    );

    bind cpu_top cpu_properties u_properties (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .bus_req_o (bus_req_o),
        .bus_rsp_i (bus_rsp_i),
        .halted_o  (halted_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////////////////////////
    // instruction encoders and stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [63:0] ris_w(opcode_e op, logic [3:0] cond, int r,
                                          logic [40:0] imm, logic [4:0] shl);
        return {op, FMT_RIS, cond, 5'(r), imm, shl};
    endfunction

    function automatic logic [63:0] rro_w(opcode_e op, logic [3:0] cond, int d, int s,
                                          logic [40:0] off);
        return {op, FMT_RRO, cond, 5'(d), 5'(s), off};
    endfunction

    function automatic logic [63:0] i_w(opcode_e op, logic [3:0] cond, logic [50:0] imm);
        return {op, FMT_I, cond, imm};
    endfunction

    // galois form, taps for a 32 bit maximal sequence
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int k = 0; k < n; k++) begin
            v = (v << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic add_row(logic [63:0] w0, logic [63:0] w1, logic [63:0] w2,
                           logic [63:0] w3, logic [63:0] w4, logic [63:0] w5,
                           logic has_st, logic [63:0] adr, logic [63:0] dat, logic err);
        row_t r;
        r.words  = {w5, w4, w3, w2, w1, w0};
        r.has_st = has_st;
        r.st_adr = adr;
        r.st_dat = dat;
        r.err    = err;
        rows.push_back(r);
    endtask

    //////////////////////////////////////////////////////////////////////
    // bus memory model, unmapped reads answer with err
    //////////////////////////////////////////////////////////////////////

    task automatic serve_request();
        if (bus_req.we) begin
            st_adr_q.push_back(bus_req.adr);
            st_dat_q.push_back(bus_req.dat);
            mem[bus_req.adr] = bus_req.dat;
            bus_rsp.ack = 1'b1;
        end else begin
            read_q.push_back(bus_req.adr);
            if (mem.exists(bus_req.adr)) begin
                bus_rsp.dat = mem[bus_req.adr];
                bus_rsp.ack = 1'b1;
            end else begin
                bus_rsp.err = 1'b1;
                err_seen    = 1'b1;
            end
        end
    endtask

    initial begin
        int waits;
        bus_rsp = '0;
        lfsr_q  = 32'd90784;
        forever begin
            @(posedge clk_i);
            #1;
            bus_rsp = '0;
            if (!rst_i && bus_req.cyc && bus_req.stb) begin
                take_bits(2, waits);
                repeat (waits % 3) begin
                    @(posedge clk_i);
                    #1;
                end
                serve_request();
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // per program run and checks
    //////////////////////////////////////////////////////////////////////

    task automatic run_row(int n);
        row_t r;
        int   cycles;
        r = rows[n];
        rst_i = 1'b1;
        mem.delete();
        read_q.delete();
        st_adr_q.delete();
        st_dat_q.delete();
        err_seen = 1'b0;
        for (int k = 0; k < 6; k++) begin
            mem[RESET_PC + 64'(8 * k)] = r.words[k];
        end
        // shared landing code for the jump and call programs
        mem[LAND]         = rro_w(OP_STORE, AL, 1, 1, 41'h18);
        mem[LAND + 64'd8] = i_w(OP_HALT, AL, '0);
        mem[DATA_ADR]     = DATA_WORD;
        repeat (16) @(posedge clk_i);
        #1;
        rst_i  = 1'b0;
        cycles = 0;
        while (!halted && cycles < 400) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        assert (halted) else begin
            $display("row %0d: core did not halt", n);
            errors++;
        end
        repeat (8) begin
            @(posedge clk_i);
            #1;
            assert (!bus_req.stb) else begin
                $display("row %0d: bus request after halt", n);
                errors++;
            end
        end
        assert (read_q.size() >= 2) else begin
            $display("row %0d: fewer than two fetches seen", n);
            errors++;
        end
        if (read_q.size() >= 2) begin
            assert (read_q[0] == RESET_PC) else begin
                $display("** Error: row %0d fetch_adr = %h, expected %h", n, read_q[0], RESET_PC);
                errors++;
            end
            assert (read_q[1] == RESET_PC + 64'd8) else begin
                $display("** Error: row %0d fetch_adr = %h, expected %h",
                         n, read_q[1], RESET_PC + 64'd8);
                errors++;
            end
        end
        assert (err_seen == r.err) else begin
            $display("** Error: row %0d bus_err = %h, expected %h", n, err_seen, r.err);
            errors++;
        end
        assert (st_adr_q.size() == int'(r.has_st)) else begin
            $display("** Error: row %0d store_count = %h, expected %h",
                     n, st_adr_q.size(), r.has_st);
            errors++;
        end
        if (r.has_st && st_adr_q.size() > 0) begin
            assert (st_adr_q[0] == r.st_adr) else begin
                $display("** Error: row %0d store_adr = %h, expected %h", n, st_adr_q[0], r.st_adr);
                errors++;
            end
            assert (st_dat_q[0] == r.st_dat) else begin
                $display("** Error: row %0d store_dat = %h, expected %h", n, st_dat_q[0], r.st_dat);
                errors++;
            end
        end
    endtask

    initial begin
        logic [63:0] hw;
        logic [63:0] set_r1;
        logic [63:0] st_r2;
        logic [63:0] st_nz;
        logic [63:0] st_z;
        rst_i       = 1'b1;
        errors      = 0;
        table_ready = 1'b0;
        hw     = i_w(OP_HALT, AL, '0);
        set_r1 = ris_w(OP_SET, AL, 1, 41'h1000, 5'd0);
        st_r2  = rro_w(OP_STORE, AL, 1, 2, '0);
        st_nz  = rro_w(OP_STORE, COND_NZ, 1, 1, '0);
        st_z   = rro_w(OP_STORE, COND_Z, 1, 1, 41'h8);

        add_row(set_r1, ris_w(OP_SET, AL, 3, 41'h3, 5'd8), rro_w(OP_SET, AL, 2, 3, '0),
                st_r2, hw, hw, 1'b1, 64'h1000, 64'h300, 1'b0);
        add_row(set_r1, ris_w(OP_SET, AL, 2, 41'h10, 0), ris_w(OP_ADD, AL, 2, 41'h25, 0),
                ris_w(OP_SUB, AL, 2, 41'h40, 0), st_r2, hw,
                1'b1, 64'h1000, 64'hffff_ffff_ffff_fff5, 1'b0);
        add_row(set_r1, ris_w(OP_SET, AL, 2, 41'h3, 0), ris_w(OP_SHIFTL, AL, 2, 41'd60, 0),
                ris_w(OP_SHIFTR, AL, 2, 41'd4, 0), st_r2, hw,
                1'b1, 64'h1000, 64'h0300_0000_0000_0000, 1'b0);
        // shift distances of a word or more clear the value
        add_row(set_r1, ris_w(OP_SET, AL, 2, 41'hff, 0), ris_w(OP_SHIFTL, AL, 2, 41'd64, 0),
                st_r2, hw, hw, 1'b1, 64'h1000, 64'h0, 1'b0);
        add_row(set_r1, ris_w(OP_SET, AL, 2, 41'hff00, 0), ris_w(OP_SHIFTR, AL, 2, 41'd72, 0),
                st_r2, hw, hw, 1'b1, 64'h1000, 64'h0, 1'b0);
        add_row(set_r1, ris_w(OP_SET, AL, 2, 41'hf0, 0), rro_w(OP_OR, AL, 2, 1, '0),
                st_r2, hw, hw, 1'b1, 64'h1000, 64'h10f0, 1'b0);
        add_row(set_r1, ris_w(OP_SET, AL, 2, 41'h31f0, 0), rro_w(OP_AND, AL, 2, 1, '0),
                st_r2, hw, hw, 1'b1, 64'h1000, 64'h1000, 1'b0);
        add_row(set_r1, ris_w(OP_SET, AL, 2, 41'h31f0, 0), rro_w(OP_XOR, AL, 2, 1, '0),
                st_r2, hw, hw, 1'b1, 64'h1000, 64'h21f0, 1'b0);
        add_row(set_r1, ris_w(OP_SET, AL, 4, 41'(DATA_ADR), 0), rro_w(OP_LOAD, AL, 2, 4, '0),
                rro_w(OP_STORE, AL, 1, 2, 41'h10), hw, hw, 1'b1, 64'h1010, DATA_WORD, 1'b0);
        // condition codes after sub and testbit
        add_row(set_r1, ris_w(OP_SET, AL, 2, 41'h1, 0), ris_w(OP_SUB, AL, 2, 41'h1, 0),
                st_nz, st_z, hw, 1'b1, 64'h1008, 64'h1000, 1'b0);
        add_row(set_r1, ris_w(OP_SET, AL, 2, 41'h2, 0), ris_w(OP_SUB, AL, 2, 41'h1, 0),
                st_nz, st_z, hw, 1'b1, 64'h1000, 64'h1000, 1'b0);
        add_row(set_r1, ris_w(OP_TESTBIT, AL, 1, 41'd0, 0), st_nz, st_z, hw, hw,
                1'b1, 64'h1008, 64'h1000, 1'b0);
        add_row(set_r1, ris_w(OP_TESTBIT, AL, 1, 41'd12, 0), st_nz, st_z, hw, hw,
                1'b1, 64'h1000, 64'h1000, 1'b0);
        // bit index past the word reads as clear
        add_row(set_r1, ris_w(OP_TESTBIT, AL, 1, 41'd76, 0), st_nz, st_z, hw, hw,
                1'b1, 64'h1008, 64'h1000, 1'b0);
        // control flow, all land on the shared code
        add_row(set_r1, i_w(OP_JUMP, AL, 51'(LAND)), rro_w(OP_STORE, AL, 1, 1, '0), hw, hw, hw,
                1'b1, 64'h1018, 64'h1000, 1'b0);
        add_row(set_r1, ris_w(OP_SET, AL, 5, 41'h10000, 5'd31), ris_w(OP_ADD, AL, 5, 41'h100, 0),
                ris_w(OP_JUMP, AL, 5, '0, 0), rro_w(OP_STORE, AL, 1, 1, '0), hw,
                1'b1, 64'h1018, 64'h1000, 1'b0);
        add_row(set_r1, ris_w(OP_SET, AL, 5, 41'h10000, 5'd31), ris_w(OP_ADD, AL, 5, 41'h200, 0),
                rro_w(OP_CALL, AL, 5, 5, 41'(-256)), rro_w(OP_STORE, AL, 1, 1, '0), hw,
                1'b1, 64'h1018, 64'h1000, 1'b0);
        // fetch from unmapped space
        add_row(set_r1, i_w(OP_JUMP, AL, 51'h5000), rro_w(OP_STORE, AL, 1, 1, '0), hw, hw, hw,
                1'b0, '0, '0, 1'b1);
        table_ready = 1'b1;

        for (int n = 0; n < rows.size(); n++) begin
            @(posedge clk_i);
            #1;
            run_row(n);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #(rows.size() * 400 * CLK_PERIOD);
        $display("watchdog: simulation ran past its time limit");
        $display("Test failures found");
        $finish;
    end

endmodule

// File: tb.f
design/cpu_pkg.sv
design/cpu_regfile.sv
design/cpu_alu.sv
design/cpu_branch.sv
design/cpu_sequencer.sv
design/cpu_top.sv
test/cpu_properties.sv
test/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
